// ==== lsu_subsys.f ====
source/lsu_pkg.sv
source/lsu_load_format.sv
source/lsu_ctrl.sv
source/lsu.sv
source/data_ram.sv
source/lsu_subsys.sv
tests/tb_lsu_subsys.sv

// ==== run.sh ====
#!/bin/sh
# builds the load/store subsystem testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ns \
	-f lsu_subsys.f --top-module tb_lsu_subsys -o sim_lsu_subsys

./obj_dir/sim_lsu_subsys | tee sim.log

if grep -q "All checks passed" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// ==== tests/tb_lsu_subsys.sv ====
//####################################################################
// testbench for the load/store subsystem
// random loads and stores checked against a word model of the RAM
//####################################################################

`timescale 1ns/1ns

module tb_lsu_subsys;

	localparam int WINDOW      = 16;   // words in the test window
	localparam int N_WORD      = 24;
	localparam int N_SUB       = 40;
	localparam int N_TIME      = 16;
	localparam int N_MIS       = 16;
	localparam int NUM_OPS     = WINDOW + 2 * N_WORD + 2 * N_SUB + N_TIME + 3 * N_MIS;
	localparam int TIMEOUT     = NUM_OPS * (lsu_pkg::MEM_WAIT + 2) + 20;
	localparam int STALL_LIMIT = 4 * lsu_pkg::MEM_WAIT + 4;

	logic             i_clk;
	logic             i_rst_n;
	lsu_pkg::lsu_op_t i_op;
	lsu_pkg::xlen_t   o_rd;
	logic             o_stall;
	logic             o_ex_ld;
	logic             o_ex_st;

	lsu_pkg::xlen_t mem_model [lsu_pkg::RAM_WORDS];
	logic [31:0]    lfsr;
	int             checks;
	int             errors;
	int             check_base;
	int             error_base;

	lsu_subsys lsu_subsys_i (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_op    (i_op),
		.o_rd    (o_rd),
		.o_stall (o_stall),
		.o_ex_ld (o_ex_ld),
		.o_ex_st (o_ex_st)
	);

	always #50 i_clk = ~i_clk;

	// taps 32, 22, 2 and 1
	function automatic lsu_pkg::xlen_t rand_bits(input int n);
		lsu_pkg::xlen_t val;
		logic           fb;
		val = '0;
		for (int k = 0; k < n; k++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val  = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic logic is_misaligned(input lsu_pkg::xlen_t addr,
					       input lsu_pkg::funct3_e f3);
		case (f3)
			lsu_pkg::LH, lsu_pkg::LHU: return addr[0];
			lsu_pkg::LW:               return addr[1] | addr[0];
			default:                   return 1'b0;
		endcase
	endfunction

	function automatic lsu_pkg::funct3_e pick_load_f3();
		case (rand_bits(3) % 5)
			0:       return lsu_pkg::LB;
			1:       return lsu_pkg::LH;
			2:       return lsu_pkg::LW;
			3:       return lsu_pkg::LBU;
			default: return lsu_pkg::LHU;
		endcase
	endfunction

	function automatic lsu_pkg::xlen_t aligned_addr(input lsu_pkg::funct3_e f3);
		lsu_pkg::xlen_t base;
		base = rand_bits(4) << 2;
		case (f3)
			lsu_pkg::LB, lsu_pkg::LBU: return base | rand_bits(2);
			lsu_pkg::LH, lsu_pkg::LHU: return base | (rand_bits(1) << 1);
			default:                   return base;
		endcase
	endfunction

	function automatic lsu_pkg::xlen_t misaligned_addr(input lsu_pkg::funct3_e f3);
		lsu_pkg::xlen_t off;
		off = rand_bits(2);
		if (f3 == lsu_pkg::LW) begin
			off = (off == 0) ? 32'd3 : off;   // any nonzero offset breaks a word
		end else begin
			off = off | 32'd1;
		end
		return (rand_bits(4) << 2) | off;
	endfunction

	task automatic model_write(input lsu_pkg::xlen_t addr, input lsu_pkg::xlen_t data,
				   input lsu_pkg::funct3_e f3);
		int idx;
		int off;
		idx = int'(addr[9:2]);
		off = int'(addr[1:0]);
		case (f3)
			lsu_pkg::LB: mem_model[idx][8*off +: 8] = data[7:0];
			lsu_pkg::LH: mem_model[idx][16*(off/2) +: 16] = data[15:0];
			default:     mem_model[idx] = data;
		endcase
	endtask

	function automatic lsu_pkg::xlen_t load_expect(input lsu_pkg::xlen_t addr,
						       input lsu_pkg::funct3_e f3);
		lsu_pkg::xlen_t w;
		logic [7:0]     b;
		logic [15:0]    h;
		int             off;
		w   = mem_model[int'(addr[9:2])];
		off = int'(addr[1:0]);
		b   = w[8*off +: 8];
		h   = w[16*(off/2) +: 16];
		case (f3)
			lsu_pkg::LB:  return {{24{b[7]}}, b};
			lsu_pkg::LH:  return {{16{h[15]}}, h};
			lsu_pkg::LBU: return {24'h0, b};
			lsu_pkg::LHU: return {16'h0, h};
			default:      return w;
		endcase
	endfunction

	task automatic check_data(input string what, input lsu_pkg::xlen_t got,
				  input lsu_pkg::xlen_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t ns: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("FAIL %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// presents one op and waits for the cycle in which o_stall is low
	task automatic run_op(input lsu_pkg::lsu_op_t op, output lsu_pkg::xlen_t rd,
			      output logic ex_ld, output logic ex_st, output int stalls);
		@(negedge i_clk);
		i_op   = op;
		stalls = 0;
		#1;
		while (o_stall && stalls < STALL_LIMIT) begin
			stalls++;
			@(negedge i_clk);
			#1;
		end
		if (o_stall) begin
			errors++;
			$display("o_stall stayed high for %0d cycles at address %h", stalls, op.addr);
		end
		rd    = o_rd;
		ex_ld = o_ex_ld;
		ex_st = o_ex_st;
	endtask

	task automatic do_store(input lsu_pkg::xlen_t addr, input lsu_pkg::xlen_t data,
				input lsu_pkg::funct3_e f3);
		lsu_pkg::lsu_op_t op;
		lsu_pkg::xlen_t   rd;
		logic             ex_ld;
		logic             ex_st;
		int               stalls;
		logic             bad;
		op.addr  = addr;
		op.wdata = data;
		op.f3    = f3;
		op.wr_en = 1'b1;
		op.rd_en = 1'b0;
		bad = is_misaligned(addr, f3);
		run_op(op, rd, ex_ld, ex_st, stalls);
		check_flag("o_ex_st", ex_st, bad);
		check_flag("o_ex_ld", ex_ld, 1'b0);
		check_count("store stall cycles", stalls, bad ? 0 : lsu_pkg::MEM_WAIT);
		if (!bad) begin
			model_write(addr, data, f3);
		end
	endtask

	task automatic do_load(input lsu_pkg::xlen_t addr, input lsu_pkg::funct3_e f3);
		lsu_pkg::lsu_op_t op;
		lsu_pkg::xlen_t   rd;
		logic             ex_ld;
		logic             ex_st;
		int               stalls;
		logic             bad;
		op.addr  = addr;
		op.wdata = '0;
		op.f3    = f3;
		op.wr_en = 1'b0;
		op.rd_en = 1'b1;
		bad = is_misaligned(addr, f3);
		run_op(op, rd, ex_ld, ex_st, stalls);
		check_flag("o_ex_ld", ex_ld, bad);
		check_flag("o_ex_st", ex_st, 1'b0);
		check_count("load stall cycles", stalls, bad ? 0 : lsu_pkg::MEM_WAIT);
		if (!bad) begin
			check_data("o_rd", rd, load_expect(addr, f3));
		end
	endtask

	task automatic end_test(input int num, input string name);
		$display("test %0d %s: %0d checks, %0d errors", num, name,
			 checks - check_base, errors - error_base);
		check_base = checks;
		error_base = errors;
	endtask

	initial begin
		repeat (TIMEOUT) @(posedge i_clk);
		$display("simulation timed out after %0d clock cycles", TIMEOUT);
		$display("Checks failed");
		$finish;
	end

	initial begin
		lsu_pkg::xlen_t   addr;
		lsu_pkg::funct3_e f3;
		i_clk      = 1'b0;
		i_rst_n    = 1'b0;
		i_op       = '0;
		lfsr       = 32'hf72c_c552;
		checks     = 0;
		errors     = 0;
		check_base = 0;
		error_base = 0;

		repeat (4) @(posedge i_clk);
		@(negedge i_clk);
		i_rst_n = 1'b1;
		#1;
		check_flag("o_stall", o_stall, 1'b0);
		check_flag("o_ex_ld", o_ex_ld, 1'b0);
		check_flag("o_ex_st", o_ex_st, 1'b0);
		end_test(1, "idle after reset");

		for (int i = 0; i < WINDOW; i++) begin
			do_store(lsu_pkg::xlen_t'(4 * i), '0, lsu_pkg::LW);   // clear the window
		end
		for (int i = 0; i < N_WORD; i++) begin
			addr = aligned_addr(lsu_pkg::LW);
			do_store(addr, rand_bits(32), lsu_pkg::LW);
			do_load(addr, lsu_pkg::LW);
		end
		end_test(2, "word store and load");

		for (int i = 0; i < N_SUB; i++) begin
			f3 = (rand_bits(1) != 0) ? lsu_pkg::LH : lsu_pkg::LB;
			do_store(aligned_addr(f3), rand_bits(32), f3);
			f3 = pick_load_f3();
			do_load(aligned_addr(f3), f3);
		end
		end_test(3, "byte and halfword lanes");

		for (int i = 0; i < N_TIME; i++) begin
			if (rand_bits(1) != 0) begin
				f3 = (rand_bits(1) != 0) ? lsu_pkg::LW : lsu_pkg::LH;
				do_store(aligned_addr(f3), rand_bits(32), f3);
			end else begin
				f3 = pick_load_f3();
				do_load(aligned_addr(f3), f3);
			end
		end
		end_test(4, "back to back stall timing");

		for (int i = 0; i < N_MIS; i++) begin
			f3   = (rand_bits(1) != 0) ? lsu_pkg::LW : lsu_pkg::LH;
			addr = misaligned_addr(f3);
			do_store(addr, rand_bits(32), f3);
			do_load({addr[31:2], 2'b00}, lsu_pkg::LW);   // word must be untouched
			f3   = (rand_bits(1) != 0) ? lsu_pkg::LW : lsu_pkg::LHU;
			do_load(misaligned_addr(f3), f3);
		end
		end_test(5, "misaligned accesses");

		@(negedge i_clk);
		i_op = '0;
		$display("%0d checks run, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== source/lsu_subsys.sv ====
//####################################################################
// load/store subsystem top
// the load/store unit in front of the data RAM
//####################################################################

`timescale 1ns/1ns

module lsu_subsys (
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  lsu_pkg::lsu_op_t i_op,
	output lsu_pkg::xlen_t   o_rd,
	output logic             o_stall,
	output logic             o_ex_ld,
	output logic             o_ex_st
);

	lsu_pkg::mem_req_t mem_req;
	logic              mem_ready;
	lsu_pkg::xlen_t    mem_rdata;

	lsu lsu_i (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op        (i_op),
		.i_mem_ready (mem_ready),
		.i_mem_rdata (mem_rdata),
		.o_mem_req   (mem_req),
		.o_rd        (o_rd),
		.o_stall     (o_stall),
		.o_ex_ld     (o_ex_ld),
		.o_ex_st     (o_ex_st)
	);

	data_ram data_ram_i (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_req   (mem_req),
		.o_ready (mem_ready),
		.o_rdata (mem_rdata)
	);

endmodule

// ==== source/data_ram.sv ====
//####################################################################
// word-organized data RAM
// byte-lane writes from funct3, fixed wait states before data-ready
//####################################################################

`timescale 1ns/1ns

module data_ram (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  lsu_pkg::mem_req_t i_req,
	output logic              o_ready,
	output lsu_pkg::xlen_t    o_rdata
);

	lsu_pkg::xlen_t ram [lsu_pkg::RAM_WORDS];

	lsu_pkg::wait_cnt_t                wait_cnt;
	lsu_pkg::word_idx_t                word_idx;
	logic [1:0]                        byte_off;
	logic                              active;
	logic [lsu_pkg::NUM_LANES-1:0]     lane_en;
	lsu_pkg::xlen_t                    wdata_sh;

	assign word_idx = i_req.addr[lsu_pkg::IDX_W+1:2];
	assign byte_off = i_req.addr[1:0];
	assign active   = i_req.wen || i_req.ren;

	// count wait states while a request is held, drop back to zero on ready
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			wait_cnt <= '0;
		end else if (o_ready) begin
			wait_cnt <= '0;
		end else if (active) begin
			wait_cnt <= wait_cnt + lsu_pkg::wait_cnt_t'(1);
		end
	end

	assign o_ready = active && (wait_cnt == lsu_pkg::WAIT_LAST);

	always_comb begin
		case (i_req.f3)
			lsu_pkg::LB,
			lsu_pkg::LBU: lane_en = 4'b0001 << byte_off;
			lsu_pkg::LH,
			lsu_pkg::LHU: lane_en = 4'b0011 << byte_off;
			lsu_pkg::LW:  lane_en = 4'b1111;
			default:      lane_en = 4'b0000;
		endcase
	end

	assign wdata_sh = i_req.wdata << {byte_off, 3'b000};   // move the store data onto its lanes

	always_ff @(posedge i_clk) begin
		if (o_ready && i_req.wen) begin
			for (int i = 0; i < lsu_pkg::NUM_LANES; i++) begin
				if (lane_en[i]) begin
					ram[word_idx][8*i +: 8] <= wdata_sh[8*i +: 8];
				end
			end
		end
	end

	// addressed byte or halfword lands in the low bits for the formatter
	assign o_rdata = ram[word_idx] >> {byte_off, 3'b000};

endmodule

// ==== source/lsu.sv ====
//####################################################################
// load/store unit
// turns a pipeline op into a memory request and formats the answer
//####################################################################

`timescale 1ns/1ns

module lsu (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  lsu_pkg::lsu_op_t  i_op,
	input  logic              i_mem_ready,
	input  lsu_pkg::xlen_t    i_mem_rdata,
	output lsu_pkg::mem_req_t o_mem_req,
	output lsu_pkg::xlen_t    o_rd,
	output logic              o_stall,
	output logic              o_ex_ld,
	output logic              o_ex_st
);

	lsu_load_format format_i (
		.i_addr  (i_op.addr),
		.i_f3    (i_op.f3),
		.i_rd_en (i_op.rd_en),
		.i_wr_en (i_op.wr_en),
		.i_rdata (i_mem_rdata),
		.o_rd    (o_rd),
		.o_ex_ld (o_ex_ld),
		.o_ex_st (o_ex_st)
	);

	lsu_ctrl ctrl_i (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_rd_en     (i_op.rd_en),
		.i_wr_en     (i_op.wr_en),
		.i_ex        (o_ex_ld || o_ex_st),
		.i_mem_ready (i_mem_ready),
		.o_stall     (o_stall)
	);

	assign o_mem_req.addr  = i_op.addr;
	assign o_mem_req.wdata = i_op.wdata;
	assign o_mem_req.f3    = i_op.f3;
	assign o_mem_req.wen   = i_op.wr_en && !o_ex_st;   // misaligned ops never reach the RAM
	assign o_mem_req.ren   = i_op.rd_en && !o_ex_ld;

endmodule

// ==== source/lsu_ctrl.sv ====
//####################################################################
// load/store control FSM
// follows one memory access and stalls the pipeline until ready
//####################################################################

`timescale 1ns/1ns

module lsu_ctrl (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_rd_en,
	input  logic i_wr_en,
	input  logic i_ex,
	input  logic i_mem_ready,
	output logic o_stall
);

	lsu_pkg::lsu_state_e state;
	lsu_pkg::lsu_state_e next_state;
	logic                req;

	assign req = i_rd_en || i_wr_en;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n || i_ex) begin
			state <= lsu_pkg::IDLE;   // a misaligned op abandons the access
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			lsu_pkg::IDLE: begin
				if (i_wr_en) begin
					next_state = lsu_pkg::WRITE;
				end else if (i_rd_en) begin
					next_state = lsu_pkg::READ;
				end
			end
			lsu_pkg::READ,
			lsu_pkg::WRITE: begin
				if (i_mem_ready) begin
					next_state = lsu_pkg::IDLE;
				end
			end
			default: next_state = lsu_pkg::IDLE;
		endcase
	end

	// the ready cycle itself is not stalled so the pipeline can move on
	assign o_stall = (state != lsu_pkg::IDLE || req) && !i_mem_ready && !i_ex;

endmodule

// ==== source/lsu_load_format.sv ====
//####################################################################
// load formatter and alignment check
// extends byte and halfword loads, flags misaligned loads and stores
//####################################################################

`timescale 1ns/1ns

module lsu_load_format (
	input  lsu_pkg::xlen_t   i_addr,
	input  lsu_pkg::funct3_e i_f3,
	input  logic             i_rd_en,
	input  logic             i_wr_en,
	input  lsu_pkg::xlen_t   i_rdata,
	output lsu_pkg::xlen_t   o_rd,
	output logic             o_ex_ld,
	output logic             o_ex_st
);

	logic misaligned;

	always_comb begin
		case (i_f3)
			lsu_pkg::LB:  o_rd = {{(lsu_pkg::XLEN-8){i_rdata[7]}}, i_rdata[7:0]};
			lsu_pkg::LH:  o_rd = {{(lsu_pkg::XLEN-16){i_rdata[15]}}, i_rdata[15:0]};
			lsu_pkg::LW:  o_rd = i_rdata;
			lsu_pkg::LBU: o_rd = {{(lsu_pkg::XLEN-8){1'b0}}, i_rdata[7:0]};
			lsu_pkg::LHU: o_rd = {{(lsu_pkg::XLEN-16){1'b0}}, i_rdata[15:0]};
			default:      o_rd = i_rdata;
		endcase
	end

	always_comb begin
		case (i_f3)
			lsu_pkg::LH,
			lsu_pkg::LHU: misaligned = i_addr[0];      // halfword needs an even address
			lsu_pkg::LW:  misaligned = |i_addr[1:0];
			default:      misaligned = 1'b0;           // bytes always fit
		endcase
	end

	assign o_ex_ld = i_rd_en && misaligned;
	assign o_ex_st = i_wr_en && misaligned;

endmodule

// ==== source/lsu_pkg.sv ====
//####################################################################
// load/store unit package
// widths, funct3 codes, the FSM states and the request structs that
// pass between the pipeline, the LSU and the data RAM
//####################################################################

package lsu_pkg;

	localparam int XLEN      = 32;
	localparam int RAM_WORDS = 256;
	localparam int MEM_WAIT  = 2;   // wait states before data-ready
	localparam int NUM_LANES = XLEN / 8;
	localparam int IDX_W     = $clog2(RAM_WORDS);
	localparam int WAIT_W    = $clog2(MEM_WAIT + 1);

	typedef logic [XLEN-1:0]   xlen_t;
	typedef logic [IDX_W-1:0]  word_idx_t;
	typedef logic [WAIT_W-1:0] wait_cnt_t;

	localparam wait_cnt_t WAIT_LAST = wait_cnt_t'(MEM_WAIT);   // counter value in the ready cycle

	// stores reuse the signed codes as SB, SH and SW
	typedef enum logic [2:0] {
		LB  = 3'b000,
		LH  = 3'b001,
		LW  = 3'b010,
		LBU = 3'b100,
		LHU = 3'b101
	} funct3_e;

	typedef enum logic [1:0] {
		IDLE  = 2'b00,
		READ  = 2'b01,
		WRITE = 2'b10
	} lsu_state_e;

	typedef struct packed {
		xlen_t   addr;
		xlen_t   wdata;
		funct3_e f3;
		logic    wen;
		logic    ren;
	} mem_req_t;

	typedef struct packed {
		xlen_t   addr;
		xlen_t   wdata;
		funct3_e f3;
		logic    wr_en;
		logic    rd_en;
	} lsu_op_t;

endpackage
